// ==== source/fm_regs_pkg.sv ====
// FM register interface definitions
package fm_regs_pkg;

	// Slot geometry, six channels of four operators
	localparam int num_slots = 24;
	localparam int slot_w = $clog2(num_slots);

	// Revolutions per timer B count
	localparam int tb_prescale = 16;

	// Global register map
	localparam logic [7:0] reg_lfo    = 8'h22;
	localparam logic [7:0] reg_clka1  = 8'h24;
	localparam logic [7:0] reg_clka2  = 8'h25;
	localparam logic [7:0] reg_clkb   = 8'h26;
	localparam logic [7:0] reg_timer  = 8'h27;
	localparam logic [7:0] reg_kon    = 8'h28;
	localparam logic [7:0] reg_pcm    = 8'h2A;
	localparam logic [7:0] reg_pcm_en = 8'h2B;

	// Operator register groups, upper address nibble
	localparam logic [3:0] grp_dt1_mul = 4'h3;
	localparam logic [3:0] grp_tl      = 4'h4;
	localparam logic [3:0] grp_ks_ar   = 4'h5;
	localparam logic [3:0] grp_am_d1r  = 4'h6;
	localparam logic [3:0] grp_d2r     = 4'h7;
	localparam logic [3:0] grp_d1l_rr  = 4'h8;
	localparam logic [3:0] grp_ssg     = 4'h9;

	// Channel register bases
	localparam logic [7:0] reg_fnum_lo    = 8'hA0;
	localparam logic [7:0] reg_block_fnum = 8'hA4;
	localparam logic [7:0] reg_fb_alg     = 8'hB0;
	localparam logic [7:0] reg_rl_ams_pms = 8'hB4;

	// Channel times 4 plus operator
	typedef logic [slot_w-1:0] slot_t;

	typedef struct packed {
		logic [2:0] dt1;
		logic [3:0] mul;
		logic [6:0] tl;
		logic [1:0] ks;
		logic [4:0] ar;
		logic       am;
		logic [4:0] d1r;
		logic [4:0] d2r;
		logic [3:0] d1l;
		logic [3:0] rr;
		logic       keyon;
		logic [1:0] spare;
	} op_regs_t;

	typedef struct packed {
		logic [10:0] fnum;
		logic [2:0]  block;
		logic [2:0]  fb;
		logic [2:0]  alg;
		logic [1:0]  rl;
		logic [1:0]  ams;
		logic [2:0]  pms;
	} ch_regs_t;

	typedef struct packed {
		logic       lfo_en;
		logic [2:0] lfo_freq;
		logic [7:0] pcm;
		logic       pcm_en;
		logic [9:0] value_a;
		logic [7:0] value_b;
		logic       irq_en_a;
		logic       irq_en_b;
	} global_regs_t;

	// One-cycle timer strobes
	typedef struct packed {
		logic load_a;
		logic load_b;
		logic clr_a;
		logic clr_b;
	} timer_cmd_t;

	typedef struct packed {
		slot_t    slot;
		op_regs_t op;
		ch_regs_t ch;
	} slot_view_t;

endpackage

// ==== source/slot_ring.sv ====
// Rotating slot store
module slot_ring import fm_regs_pkg::*; #(
	parameter type payload_t = logic [7:0]
) (
	input  logic     clk,
	input  logic     rst,
	input  logic     wr,
	input  payload_t wdata,
	output payload_t head
);

	payload_t store [num_slots];

	// Entry of the current slot
	assign head = store[0];

	// Head goes to the tail each cycle, replaced on the way when written
	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < num_slots; i++) begin
				store[i] <= '0;
			end
		end else begin
			for (int i = 0; i < num_slots - 1; i++) begin
				store[i] <= store[i + 1];
			end
			store[num_slots - 1] <= wr ? wdata : store[0];
		end
	end

endmodule

// ==== source/mmr_ctrl.sv ====
// Host register decoder
module mmr_ctrl import fm_regs_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         write,
	input  logic [1:0]   addr,
	input  logic [7:0]   din,
	input  op_regs_t     op_head,
	input  ch_regs_t     ch_head,
	output logic         busy,
	output slot_t        slot,
	output logic         rev,
	output logic         op_wr,
	output op_regs_t     op_wdata,
	output logic         ch_wr,
	output ch_regs_t     ch_wdata,
	output global_regs_t gregs,
	output timer_cmd_t   tcmd
);

	typedef enum logic [1:0] {pend_none, pend_op, pend_ch, pend_kon} pend_t;

	logic [7:0] sel_reg;
	logic [2:0] sel_ch;
	logic [1:0] sel_op;
	logic       sel_ok;
	pend_t      pend;
	logic [2:0] tgt_ch;
	logic [1:0] tgt_op;
	logic [7:0] data_lat;
	logic [4:0] win_cnt;
	logic       run_a;
	logic       run_b;
	logic       accept;
	logic [7:0] ch_base;
	logic       is_ch_reg;
	logic       is_op_reg;
	logic       at_target;
	logic       in_channel;
	logic       kon_bit;

	// Bank 1 holds channels 3 to 5
	function automatic logic [2:0] chan_index(logic bank, logic [1:0] sub);
		return bank ? 3'(sub) + 3'd3 : 3'(sub);
	endfunction

	function automatic op_regs_t merge_op(op_regs_t cur, logic [3:0] grp, logic [7:0] d);
		op_regs_t nxt;
		nxt = cur;
		case (grp)
			grp_dt1_mul: begin
				nxt.dt1 = d[6:4];
				nxt.mul = d[3:0];
			end
			grp_tl: nxt.tl = d[6:0];
			grp_ks_ar: begin
				nxt.ks = d[7:6];
				nxt.ar = d[4:0];
			end
			grp_am_d1r: begin
				nxt.am  = d[7];
				nxt.d1r = d[4:0];
			end
			grp_d2r: nxt.d2r = d[4:0];
			grp_d1l_rr: begin
				nxt.d1l = d[7:4];
				nxt.rr  = d[3:0];
			end
			// SSG group is not kept
			default: ;
		endcase
		return nxt;
	endfunction

	function automatic ch_regs_t merge_ch(ch_regs_t cur, logic [7:0] base, logic [7:0] d);
		ch_regs_t nxt;
		nxt = cur;
		case (base)
			reg_fnum_lo: nxt.fnum[7:0] = d;
			reg_block_fnum: begin
				nxt.block      = d[5:3];
				nxt.fnum[10:8] = d[2:0];
			end
			reg_fb_alg: begin
				nxt.fb  = d[5:3];
				nxt.alg = d[2:0];
			end
			reg_rl_ams_pms: begin
				nxt.rl  = d[7:6];
				nxt.ams = d[5:4];
				nxt.pms = d[2:0];
			end
			default: ;
		endcase
		return nxt;
	endfunction

	assign accept     = write && !busy;
	assign ch_base    = {sel_reg[7:2], 2'b00};
	assign is_ch_reg  = ch_base == reg_fnum_lo || ch_base == reg_block_fnum ||
		ch_base == reg_fb_alg || ch_base == reg_rl_ams_pms;
	assign is_op_reg  = sel_reg[7:4] >= grp_dt1_mul && sel_reg[7:4] <= grp_ssg;
	assign at_target  = slot == {tgt_ch, tgt_op};
	assign in_channel = slot[4:2] == tgt_ch;

	// Mask bit 4+n keys operator n of the channel
	assign kon_bit = data_lat[3'd4 + 3'(slot[1:0])];

	// Head payload with the latched byte merged in
	assign op_wr = (pend == pend_op && at_target) || (pend == pend_kon && in_channel);
	assign ch_wr = pend == pend_ch && in_channel;
	assign ch_wdata = merge_ch(ch_head, ch_base, data_lat);

	always_comb begin
		op_wdata = merge_op(op_head, sel_reg[7:4], data_lat);
		if (pend == pend_kon) begin
			op_wdata.keyon = kon_bit;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			slot    <= '0;
			rev     <= 1'b0;
			busy    <= 1'b0;
			pend    <= pend_none;
			win_cnt <= '0;
			sel_reg <= '0;
			sel_ok  <= 1'b0;
			run_a   <= 1'b0;
			run_b   <= 1'b0;
			gregs   <= '0;
			tcmd    <= '0;
		end else begin
			slot <= (slot == slot_t'(num_slots - 1)) ? '0 : slot + 1'b1;
			rev  <= slot == slot_t'(num_slots - 1);
			tcmd <= '0;
			if (accept) begin
				busy <= 1'b1;
				if (!addr[0]) begin
					sel_reg <= din;
					sel_ok  <= din[1:0] != 2'b11;
				end else if (sel_reg < 8'h30) begin
					case (sel_reg)
						reg_lfo: {gregs.lfo_en, gregs.lfo_freq} <= din[3:0];
						reg_clka1: gregs.value_a[9:2] <= din;
						reg_clka2: gregs.value_a[1:0] <= din[1:0];
						reg_clkb: gregs.value_b <= din;
						reg_timer: begin
							gregs.irq_en_a <= din[2];
							gregs.irq_en_b <= din[3];
							// Load strobes only on a change of the run bit
							tcmd.load_a <= din[0] != run_a;
							tcmd.load_b <= din[1] != run_b;
							tcmd.clr_a  <= din[4];
							tcmd.clr_b  <= din[5];
							run_a <= din[0];
							run_b <= din[1];
						end
						reg_kon: begin
							if (din[1:0] != 2'b11) begin
								pend    <= pend_kon;
								win_cnt <= 5'(num_slots - 1);
							end
						end
						reg_pcm: gregs.pcm <= din;
						reg_pcm_en: gregs.pcm_en <= din[7];
						default: ;
					endcase
				end else if (sel_ok && is_ch_reg) begin
					pend    <= pend_ch;
					win_cnt <= 5'(num_slots - 1);
				end else if (sel_ok && is_op_reg) begin
					pend <= pend_op;
				end
			end else begin
				case (pend)
					pend_op: begin
						if (at_target) begin
							pend <= pend_none;
							busy <= 1'b0;
						end
					end
					// One full revolution covers all four slots
					pend_ch, pend_kon: begin
						if (win_cnt == '0) begin
							pend <= pend_none;
							busy <= 1'b0;
						end else begin
							win_cnt <= win_cnt - 1'b1;
						end
					end
					default: busy <= 1'b0;
				endcase
			end
		end
	end

	// Select and data latches
	always_ff @(posedge clk) begin
		if (accept && !addr[0]) begin
			sel_ch <= chan_index(addr[1], din[1:0]);
			sel_op <= din[3:2];
		end
		if (accept && addr[0]) begin
			data_lat <= din;
			if (sel_reg == reg_kon) begin
				tgt_ch <= chan_index(din[2], din[1:0]);
				tgt_op <= 2'd0;
			end else begin
				tgt_ch <= sel_ch;
				tgt_op <= sel_op;
			end
		end
	end

endmodule

// ==== source/fm_timers.sv ====
// Timers A and B
module fm_timers import fm_regs_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         rev,
	input  global_regs_t gregs,
	input  timer_cmd_t   tcmd,
	output logic         flag_a,
	output logic         flag_b,
	output logic         irq
);

	localparam int pre_w = $clog2(tb_prescale);

	logic             run_a;
	logic             run_b;
	logic [9:0]       cnt_a;
	logic [7:0]       cnt_b;
	logic [pre_w-1:0] pre_b;
	logic             tick_b;

	assign tick_b = rev && run_b && pre_b == pre_w'(tb_prescale - 1);
	assign irq    = flag_a | flag_b;

	always_ff @(posedge clk) begin
		if (rst) begin
			run_a  <= 1'b0;
			run_b  <= 1'b0;
			cnt_a  <= '0;
			cnt_b  <= '0;
			pre_b  <= '0;
			flag_a <= 1'b0;
			flag_b <= 1'b0;
		end else begin
			// Start or stop, both reload the counter
			if (tcmd.load_a) begin
				run_a <= ~run_a;
				cnt_a <= gregs.value_a;
			end else if (run_a && rev) begin
				if (&cnt_a) begin
					cnt_a <= gregs.value_a;
					if (gregs.irq_en_a)
						flag_a <= 1'b1;
				end else begin
					cnt_a <= cnt_a + 1'b1;
				end
			end

			if (tcmd.load_b) begin
				run_b <= ~run_b;
				cnt_b <= gregs.value_b;
				pre_b <= '0;
			end else if (run_b && rev) begin
				pre_b <= tick_b ? '0 : pre_b + 1'b1;
				if (tick_b) begin
					if (&cnt_b) begin
						cnt_b <= gregs.value_b;
						if (gregs.irq_en_b)
							flag_b <= 1'b1;
					end else begin
						cnt_b <= cnt_b + 1'b1;
					end
				end
			end

			// Clear wins over a same-cycle overflow
			if (tcmd.clr_a)
				flag_a <= 1'b0;
			if (tcmd.clr_b)
				flag_b <= 1'b0;
		end
	end

endmodule

// ==== source/fm_regs_top.sv ====
// FM register interface top level
module fm_regs_top import fm_regs_pkg::*; (
	input  logic         clk,
	input  logic         rst,
	input  logic         write,
	input  logic [1:0]   addr,
	input  logic [7:0]   din,
	output logic         busy,
	output logic         irq,
	output logic         flag_a,
	output logic         flag_b,
	output global_regs_t gregs,
	output slot_view_t   slot_view
);

	slot_t      slot;
	logic       rev;
	logic       op_wr;
	op_regs_t   op_wdata;
	op_regs_t   op_head;
	logic       ch_wr;
	ch_regs_t   ch_wdata;
	ch_regs_t   ch_head;
	timer_cmd_t tcmd;

	mmr_ctrl u_ctrl (
		.clk      (clk),
		.rst      (rst),
		.write    (write),
		.addr     (addr),
		.din      (din),
		.op_head  (op_head),
		.ch_head  (ch_head),
		.busy     (busy),
		.slot     (slot),
		.rev      (rev),
		.op_wr    (op_wr),
		.op_wdata (op_wdata),
		.ch_wr    (ch_wr),
		.ch_wdata (ch_wdata),
		.gregs    (gregs),
		.tcmd     (tcmd)
	);

	slot_ring #(.payload_t(op_regs_t)) op_ring (
		.clk   (clk),
		.rst   (rst),
		.wr    (op_wr),
		.wdata (op_wdata),
		.head  (op_head)
	);

	slot_ring #(.payload_t(ch_regs_t)) ch_ring (
		.clk   (clk),
		.rst   (rst),
		.wr    (ch_wr),
		.wdata (ch_wdata),
		.head  (ch_head)
	);

	fm_timers u_timers (
		.clk    (clk),
		.rst    (rst),
		.rev    (rev),
		.gregs  (gregs),
		.tcmd   (tcmd),
		.flag_a (flag_a),
		.flag_b (flag_b),
		.irq    (irq)
	);

	// Ring heads as the pipeline sees them, one cycle late
	always_ff @(posedge clk) begin
		slot_view <= '{slot: slot, op: op_head, ch: ch_head};
	end

endmodule

// ==== verification/fm_regs_checker.sv ====
// Register decoder assertions
module fm_regs_checker import fm_regs_pkg::*; (
	input logic       clk,
	input logic       rst,
	input logic       write,
	input logic       busy,
	input logic [1:0] addr,
	input logic [7:0] din,
	input logic [7:0] sel_reg,
	input logic       sel_ok,
	input logic       is_ch_reg,
	input timer_cmd_t tcmd
);

	logic       ch_start;
	logic       ch_active;
	logic [5:0] busy_len;

	// Accepted channel or key-on data write
	assign ch_start = write && !busy && addr[0] &&
		((sel_ok && is_ch_reg) || (sel_reg == reg_kon && din[1:0] != 2'b11));

	always_ff @(posedge clk) begin
		if (rst) begin
			ch_active <= 1'b0;
			busy_len  <= '0;
		end else begin
			busy_len <= busy ? busy_len + 6'd1 : 6'd0;
			if (ch_start)
				ch_active <= 1'b1;
			else if (!busy)
				ch_active <= 1'b0;
		end
	end

	a_busy_reset: assert property (@(posedge clk) rst |=> !busy)
		else $error("busy not low after reset");

	a_tcmd_pulse: assert property (@(posedge clk) disable iff (rst) tcmd != '0 |=> tcmd == '0)
		else $error("timer strobe longer than one cycle");

	a_ch_busy: assert property (@(posedge clk) disable iff (rst)
		ch_active && $fell(busy) |-> busy_len == 6'd24)
		else $error("channel write busy length not 24 cycles");

endmodule

bind mmr_ctrl fm_regs_checker u_checker (
	.clk       (clk),
	.rst       (rst),
	.write     (write),
	.busy      (busy),
	.addr      (addr),
	.din       (din),
	.sel_reg   (sel_reg),
	.sel_ok    (sel_ok),
	.is_ch_reg (is_ch_reg),
	.tcmd      (tcmd)
);

// ==== verification/tb_clock.sv ====
// Testbench clock source
module tb_clock #(
	parameter int period = 40
) (
	output logic clk
);

	initial begin
		clk = 1'b0;
		forever begin
			#(period / 2) clk = ~clk;
		end
	end

endmodule

// ==== verification/fm_regs_tb.sv ====
// FM register interface testbench
module fm_regs_tb import fm_regs_pkg::*;;

	localparam int n_global = 6;
	localparam int n_op     = 70;
	localparam int n_ch     = 24;
	localparam int n_kon    = 12;
	localparam int n_timer  = 10;
	// Each register access is a select and a data write
	localparam int n_port   = 2 * (n_global + n_op + n_ch + n_kon + n_timer);

	logic         clk;
	logic         rst;
	logic         write;
	logic [1:0]   addr;
	logic [7:0]   din;
	logic         busy;
	logic         irq;
	logic         flag_a;
	logic         flag_b;
	global_regs_t gregs;
	slot_view_t   slot_view;

	op_regs_t     op_model [num_slots];
	ch_regs_t     ch_model [num_slots];
	global_regs_t g_model;
	integer       seed;
	logic         cmp_req;
	logic         cmp_ack;

	tb_clock #(.period(40)) u_clock (.clk(clk));

	fm_regs_top DUT (
		.clk       (clk),
		.rst       (rst),
		.write     (write),
		.addr      (addr),
		.din       (din),
		.busy      (busy),
		.irq       (irq),
		.flag_a    (flag_a),
		.flag_b    (flag_b),
		.gregs     (gregs),
		.slot_view (slot_view)
	);

	task automatic stop_on_error(string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1, "simulation stopped at first error");
	endtask

	task automatic check_op(op_regs_t got, op_regs_t exp, int s);
		if (got !== exp)
			stop_on_error($sformatf("** Error at %0t: slot %0d operator %h, expected %h",
				$time, s, got, exp));
	endtask

	task automatic check_ch(ch_regs_t got, ch_regs_t exp, int s);
		if (got !== exp)
			stop_on_error($sformatf("** Error at %0t: slot %0d channel %h, expected %h",
				$time, s, got, exp));
	endtask

	task automatic check_globals(global_regs_t got, global_regs_t exp);
		if (got !== exp)
			stop_on_error($sformatf("** Error at %0t: globals %h, expected %h",
				$time, got, exp));
	endtask

	task automatic check_flag(string name, logic got, logic exp);
		if (got !== exp)
			stop_on_error($sformatf("** Error at %0t: %s is %b, expected %b",
				$time, name, got, exp));
	endtask

	task automatic check_busy_len(string what, int got, int lo, int hi);
		if (got < lo || got > hi)
			stop_on_error($sformatf("** Error at %0t: %s busy %0d cycles, expected %0d to %0d",
				$time, what, got, lo, hi));
	endtask

	// Expected register contents after one data write
	function automatic op_regs_t ref_op(op_regs_t cur, logic [3:0] grp, logic [7:0] d);
		op_regs_t r;
		r = cur;
		if (grp == 4'h3) {r.dt1, r.mul} = {d[6:4], d[3:0]};
		if (grp == 4'h4) r.tl = d[6:0];
		if (grp == 4'h5) {r.ks, r.ar} = {d[7:6], d[4:0]};
		if (grp == 4'h6) {r.am, r.d1r} = {d[7], d[4:0]};
		if (grp == 4'h7) r.d2r = d[4:0];
		if (grp == 4'h8) {r.d1l, r.rr} = d;
		return r;
	endfunction

	function automatic ch_regs_t ref_ch(ch_regs_t cur, logic [7:0] base, logic [7:0] d);
		ch_regs_t r;
		r = cur;
		if (base == 8'hA0) r.fnum[7:0] = d;
		if (base == 8'hA4) {r.block, r.fnum[10:8]} = d[5:0];
		if (base == 8'hB0) {r.fb, r.alg} = d[5:0];
		if (base == 8'hB4) {r.rl, r.ams, r.pms} = {d[7:4], d[2:0]};
		return r;
	endfunction

	function automatic global_regs_t ref_globals(global_regs_t cur, logic [7:0] ra,
		logic [7:0] d);
		global_regs_t r;
		r = cur;
		if (ra == 8'h22) {r.lfo_en, r.lfo_freq} = d[3:0];
		if (ra == 8'h24) r.value_a[9:2] = d;
		if (ra == 8'h25) r.value_a[1:0] = d[1:0];
		if (ra == 8'h26) r.value_b = d;
		if (ra == 8'h27) {r.irq_en_b, r.irq_en_a} = d[3:2];
		if (ra == 8'h2A) r.pcm = d;
		if (ra == 8'h2B) r.pcm_en = d[7];
		return r;
	endfunction

	task automatic model_write(logic bank, logic [7:0] ra, logic [7:0] d);
		int ch;
		int s;
		if (ra < 8'h30) begin
			g_model = ref_globals(g_model, ra, d);
			if (ra == 8'h28 && d[1:0] != 2'b11) begin
				ch = (d[2] ? 3 : 0) + int'(d[1:0]);
				for (int n = 0; n < 4; n++) begin
					op_model[ch * 4 + n].keyon = d[4 + n];
				end
			end
		end else if (ra[1:0] != 2'b11) begin
			ch = (bank ? 3 : 0) + int'(ra[1:0]);
			if (ra[7:4] <= 4'h9) begin
				s = ch * 4 + int'(ra[3:2]);
				op_model[s] = ref_op(op_model[s], ra[7:4], d);
			end else begin
				for (int n = 0; n < 4; n++) begin
					ch_model[ch * 4 + n] = ref_ch(ch_model[ch * 4 + n], {ra[7:2], 2'b00}, d);
				end
			end
		end
	endtask

	// Drives one port write on the falling edge and waits for busy to drop
	task automatic port_write(logic [1:0] a, logic [7:0] d, output int busy_cycles);
		busy_cycles = 0;
		write = 1'b1;
		addr  = a;
		din   = d;
		@(negedge clk);
		write = 1'b0;
		while (busy) begin
			busy_cycles++;
			if (busy_cycles > 40)
				stop_on_error("busy stayed high, the write never completed");
			@(negedge clk);
		end
	endtask

	task automatic reg_write(logic bank, logic [7:0] ra, logic [7:0] d, output int busy_cycles);
		int sel_cycles;
		port_write({bank, 1'b0}, ra, sel_cycles);
		check_busy_len("select", sel_cycles, 1, 1);
		port_write({bank, 1'b1}, d, busy_cycles);
		model_write(bank, ra, d);
	endtask

	task automatic compare_ring();
		cmp_req = 1'b1;
		wait (cmp_ack);
		cmp_req = 1'b0;
		wait (!cmp_ack);
	endtask

	function automatic int rnd_below(int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// Ring compare over one full revolution of slot_view
	always begin
		wait (cmp_req);
		@(negedge clk);
		for (int i = 0; i < num_slots; i++) begin
			@(negedge clk);
			check_op(slot_view.op, op_model[int'(slot_view.slot)], int'(slot_view.slot));
			check_ch(slot_view.ch, ch_model[int'(slot_view.slot)], int'(slot_view.slot));
		end
		check_globals(gregs, g_model);
		cmp_ack = 1'b1;
		wait (!cmp_req);
		cmp_ack = 1'b0;
	end

	initial begin
		repeat (n_port * 30 + 4000 + 16) @(posedge clk);
		$display("Watchdog expired before the tests finished");
		$display("SOME TESTS FAILED");
		$fatal(1, "watchdog timeout");
	end

	initial begin
		int bc;
		int cnt;
		logic bank;
		logic [7:0] ra;
		logic [7:0] bases [4];
		rst = 1'b1;
		write = 1'b0;
		addr = 2'b00;
		din = 8'h00;
		cmp_req = 1'b0;
		cmp_ack = 1'b0;
		seed = 32'h800c_07f6;
		g_model = '0;
		bases = '{8'hA0, 8'hA4, 8'hB0, 8'hB4};
		for (int i = 0; i < num_slots; i++) begin
			op_model[i] = '0;
			ch_model[i] = '0;
		end
		repeat (16) @(negedge clk);
		rst = 1'b0;
		@(negedge clk);
		check_flag("busy", busy, 1'b0);
		check_flag("irq", irq, 1'b0);

		// Global registers
		reg_write(1'b0, reg_lfo, 8'($random(seed)), bc);
		check_globals(gregs, g_model);
		reg_write(1'b0, reg_pcm, 8'($random(seed)), bc);
		check_globals(gregs, g_model);
		reg_write(1'b0, reg_pcm_en, 8'($random(seed)), bc);
		check_globals(gregs, g_model);
		reg_write(1'b0, reg_clka1, 8'($random(seed)), bc);
		check_globals(gregs, g_model);
		reg_write(1'b0, reg_clka2, 8'($random(seed)), bc);
		check_globals(gregs, g_model);
		reg_write(1'b0, reg_clkb, 8'($random(seed)), bc);
		check_busy_len("global", bc, 1, 1);
		check_globals(gregs, g_model);

		// Operator groups 3 to 9 in both banks
		for (int i = 0; i < n_op; i++) begin
			bank = rnd_below(2) == 1;
			ra = {4'(3 + rnd_below(7)), 2'(rnd_below(4)), 2'(rnd_below(4))};
			reg_write(bank, ra, 8'($random(seed)), bc);
			check_busy_len("operator", bc, 1, num_slots);
			compare_ring();
		end

		// Channel registers, channel field 3 included
		for (int i = 0; i < n_ch; i++) begin
			bank = rnd_below(2) == 1;
			ra = bases[rnd_below(4)] | 8'(rnd_below(4));
			reg_write(bank, ra, 8'($random(seed)), bc);
			compare_ring();
		end

		// Key-on with random operator masks
		for (int i = 0; i < n_kon; i++) begin
			reg_write(1'b0, reg_kon,
				{4'($random(seed)), 1'b0, 1'(rnd_below(2)), 2'(rnd_below(3))}, bc);
			check_busy_len("key-on", bc, num_slots, num_slots);
			compare_ring();
		end

		// Timer A at 1020 with its interrupt enabled
		reg_write(1'b0, reg_clka1, 8'hFF, bc);
		reg_write(1'b0, reg_clka2, 8'h00, bc);
		reg_write(1'b0, reg_timer, 8'h05, bc);
		check_globals(gregs, g_model);
		cnt = 0;
		while (!flag_a && cnt < 5 * num_slots) begin
			@(negedge clk);
			cnt++;
		end
		check_flag("flag_a", flag_a, 1'b1);
		check_flag("irq", irq, 1'b1);
		reg_write(1'b0, reg_timer, 8'h15, bc);
		check_flag("flag_a", flag_a, 1'b0);
		reg_write(1'b0, reg_timer, 8'h10, bc);
		check_flag("irq", irq, 1'b0);

		// Timer B at 254
		reg_write(1'b0, reg_clkb, 8'd254, bc);
		reg_write(1'b0, reg_timer, 8'h0A, bc);
		check_globals(gregs, g_model);
		cnt = 0;
		while (!flag_b && cnt < 40 * num_slots) begin
			@(negedge clk);
			cnt++;
		end
		check_flag("flag_b", flag_b, 1'b1);
		check_flag("irq", irq, 1'b1);
		check_flag("flag_a", flag_a, 1'b0);
		reg_write(1'b0, reg_timer, 8'h20, bc);
		check_flag("flag_b", flag_b, 1'b0);
		check_flag("irq", irq, 1'b0);

		// Both running with interrupts off
		reg_write(1'b0, reg_timer, 8'h03, bc);
		repeat (40 * num_slots) begin
			@(negedge clk);
			check_flag("flag_a", flag_a, 1'b0);
			check_flag("flag_b", flag_b, 1'b0);
		end
		reg_write(1'b0, reg_timer, 8'h00, bc);
		check_globals(gregs, g_model);
		check_flag("irq", irq, 1'b0);

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// ==== tb.f ====
source/fm_regs_pkg.sv
source/slot_ring.sv
source/mmr_ctrl.sv
source/fm_timers.sv
source/fm_regs_top.sv
verification/fm_regs_checker.sv
verification/tb_clock.sv
verification/fm_regs_tb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the register interface testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module fm_regs_tb -o sim_fm_regs

out=$(./obj_dir/sim_fm_regs) || true
echo "$out"
echo "$out" | grep -q "ALL TESTS PASSED"
